// ==== project.f ====
+incdir+sim
logic/soc_pkg.sv
logic/reset_sequencer.sv
logic/bus_decoder.sv
logic/led_port.sv
logic/interval_timer.sv
logic/prng_port.sv
logic/scratch_ram.sv
logic/soc_top.sv
sim/soc_assertions.sv
sim/soc_tb.sv

// ==== Makefile ====
VERILATOR = verilator
SIM_FLAGS = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing
TOP = soc_tb
FILELIST = project.f
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# pass only when the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/soc_model.svh ====
`ifndef SOC_MODEL_SVH
`define SOC_MODEL_SVH

// expected state of the peripherals, updated as the testbench drives the bus
logic [DATA_W-1:0] exp_ram [1024];
bit                exp_ram_valid [1024];
logic [DATA_W-1:0] exp_leds    = '0;
logic [31:0]       exp_prng    = 32'h2545F491;
logic [15:0]       exp_reload  = '0;
logic [DATA_W-1:0] exp_ctrl    = '0;
logic              exp_expired = 1'b0;

// page decode, anything unclaimed lands in ram
function automatic slave_e decode_page(input logic [ADDR_W-1:0] adr);
    if (adr[31:8] == 24'hFFFFFD) begin
        return SLV_TIMER;
    end
    if (adr[31:8] == 24'hFFFFFE) begin
        return SLV_PRNG;
    end
    if (adr[31:4] == 28'hFFFFFFF) begin
        return SLV_LEDS;
    end
    return SLV_RAM;
endfunction

// 1 KiB of ram, aliased across the whole default region
function automatic int ram_index(input logic [ADDR_W-1:0] adr);
    return int'(adr % 1024);
endfunction

// xorshift32 with shifts 13 left, 17 right, 5 left
function automatic logic [31:0] xorshift_step(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
endfunction

// irq follows the expired flag gated by interrupt enable
function automatic logic expected_irq();
    return exp_expired && exp_ctrl[1];
endfunction

`endif

// ==== sim/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb;
    import soc_pkg::*;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 4;
    localparam int BUTTON_CYCLES = 8;
    localparam int ACK_TIMEOUT   = 64;
    localparam int RAND_SEED     = 12924;
    localparam int RAM_OPS       = 300;
    localparam int LED_OPS       = 12;
    localparam int PRNG_READS    = 40;

    logic              clk;
    logic              rst_n_i;
    logic              reset_button_n_i;
    wb_req_t           bus_i;
    wb_rsp_t           bus_o;
    logic [DATA_W-1:0] leds_o;
    logic              irq_o;

    `include "soc_model.svh"

    soc_top uut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .reset_button_n_i (reset_button_n_i),
        .bus_i            (bus_i),
        .bus_o            (bus_o),
        .leds_o           (leds_o),
        .irq_o            (irq_o)
    );

    bind soc_top soc_assertions u_soc_assertions (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .sys_rst_i (sys_rst),
        .bus_i     (bus_i),
        .ack_i     (bus_o.ack),
        .irq_i     (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic start_request(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                                 input logic we);
        @(posedge clk);
        #1;
        bus_i.adr = adr;
        bus_i.dat = dat;
        bus_i.we  = we;
        bus_i.stb = 1'b1;
    endtask

    // stb drops in the ack cycle, the address stays until the next request
    task automatic wait_ack(output logic [DATA_W-1:0] rdata);
        int cycles;
        cycles = 0;
        rdata  = '0;
        while (bus_i.stb) begin
            @(posedge clk);
            #1;
            if (bus_o.ack) begin
                rdata     = bus_o.dat;
                bus_i.stb = 1'b0;
            end else begin
                cycles++;
                if (cycles > ACK_TIMEOUT) begin
                    abort_run($sformatf("no ack within %0d cycles for address 0x%08h",
                                        ACK_TIMEOUT, bus_i.adr));
                end
            end
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
        logic [DATA_W-1:0] unused;
        start_request(adr, dat, 1'b1);
        wait_ack(unused);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] adr, output logic [DATA_W-1:0] dat);
        start_request(adr, '0, 1'b0);
        wait_ack(dat);
    endtask

    function automatic logic [ADDR_W-1:0] timer_addr(input timer_reg_e r);
        return {TIMER_PAGE, 6'd0, r};
    endfunction

    function automatic logic [ADDR_W-1:0] random_ram_address();
        logic [ADDR_W-1:0] adr;
        do begin
            adr = $urandom;
            // often aim at the io area of the dropped peripherals
            if ($urandom_range(1, 0) == 1) begin
                adr[ADDR_W-1:12] = 20'hFFFFF;
            end
        end while (decode_page(adr) != SLV_RAM);
        return adr;
    endfunction

    task automatic check_reset_hold();
        logic [DATA_W-1:0] rdata;
        // button goes down together with a read of the led page
        start_request({LEDS_PAGE, 4'h0}, '0, 1'b0);
        reset_button_n_i = 1'b0;
        repeat (BUTTON_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("bus_o.ack", 32'(bus_o.ack), 32'd0);
        end
        reset_button_n_i = 1'b1;
        repeat (RESET_HOLD_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("bus_o.ack", 32'(bus_o.ack), 32'd0);
        end
        wait_ack(rdata);
        check_value("bus_o.dat (leds)", 32'(rdata), 32'(exp_leds));
        check_value("leds_o", 32'(leds_o), 32'd0);
    endtask

    task automatic check_ram();
        int                idx_q[$];
        int                idx;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        for (int i = 0; i < RAM_OPS; i++) begin
            adr = random_ram_address();
            if (idx_q.size() == 0 || $urandom_range(1, 0) == 0) begin
                dat = DATA_W'($urandom);
                bus_write(adr, dat);
                idx = ram_index(adr);
                if (!exp_ram_valid[idx]) begin
                    idx_q.push_back(idx);
                end
                exp_ram_valid[idx] = 1'b1;
                exp_ram[idx]       = dat;
            end else begin
                // revisit a written byte, usually through another alias
                idx = idx_q[$urandom_range(idx_q.size() - 1, 0)];
                do begin
                    adr = random_ram_address();
                    adr[RAM_ADDR_BITS-1:0] = RAM_ADDR_BITS'(idx);
                end while (decode_page(adr) != SLV_RAM);
                bus_read(adr, dat);
                check_value($sformatf("bus_o.dat (ram 0x%08h)", adr), 32'(dat),
                            32'(exp_ram[idx]));
            end
        end
    endtask

    task automatic check_leds();
        logic [DATA_W-1:0] dat;
        for (int i = 0; i < LED_OPS; i++) begin
            dat = DATA_W'($urandom);
            bus_write({LEDS_PAGE, 4'($urandom)}, dat);
            exp_leds = dat;
            check_value("leds_o", 32'(leds_o), 32'(exp_leds));
            bus_read({LEDS_PAGE, 4'($urandom)}, dat);
            check_value("bus_o.dat (leds)", 32'(dat), 32'(exp_leds));
        end
    endtask

    task automatic check_prng();
        logic [31:0]       seed;
        logic [DATA_W-1:0] dat;
        int                offs;
        do begin
            seed = $urandom;
        end while (seed == 32'd0);
        for (int b = 0; b < 4; b++) begin
            bus_write({PRNG_PAGE, 8'(b)}, seed[8*b +: 8]);
        end
        exp_prng = seed;
        for (int i = 0; i < PRNG_READS; i++) begin
            // mostly offset 0, now and then a look at an upper byte
            offs = ($urandom_range(2, 0) == 0) ? int'($urandom_range(3, 1)) : 0;
            bus_read({PRNG_PAGE, 8'(offs)}, dat);
            check_value($sformatf("bus_o.dat (prng byte %0d)", offs), 32'(dat),
                        32'(exp_prng[8*offs +: 8]));
            if (offs == 0) begin
                exp_prng = xorshift_step(exp_prng);
            end
        end
    endtask

    task automatic check_timer();
        int                reload;
        int                cycles;
        logic [DATA_W-1:0] dat;
        reload = int'($urandom_range(60, 4));
        bus_write(timer_addr(TMR_RELOAD_LO), 8'(reload));
        bus_write(timer_addr(TMR_RELOAD_HI), 8'(reload >> 8));
        exp_reload = 16'(reload);
        bus_read(timer_addr(TMR_RELOAD_LO), dat);
        check_value("bus_o.dat (reload lo)", 32'(dat), 32'(exp_reload[7:0]));
        bus_write(timer_addr(TMR_CTRL), 8'h03);
        exp_ctrl = 8'h03;
        cycles   = 0;
        while (!irq_o) begin
            @(posedge clk);
            #1;
            cycles++;
            if (!irq_o && cycles >= reload + 3) begin
                abort_run($sformatf("timer irq missing %0d cycles after enable, reload %0d",
                                    cycles, reload));
            end
        end
        if (cycles < reload + 1) begin
            abort_run($sformatf("timer irq after only %0d cycles, reload %0d", cycles, reload));
        end
        exp_expired = 1'b1;
        bus_read(timer_addr(TMR_STATUS), dat);
        check_value("bus_o.dat (status)", 32'(dat), 32'(exp_expired));
        // stop counting but keep the interrupt enabled
        bus_write(timer_addr(TMR_CTRL), 8'h02);
        exp_ctrl = 8'h02;
        bus_read(timer_addr(TMR_CTRL), dat);
        check_value("bus_o.dat (ctrl)", 32'(dat), 32'(exp_ctrl));
        check_value("irq_o", 32'(irq_o), 32'(expected_irq()));
        bus_write(timer_addr(TMR_STATUS), 8'h01);
        exp_expired = 1'b0;
        check_value("irq_o", 32'(irq_o), 32'(expected_irq()));
        bus_read(timer_addr(TMR_STATUS), dat);
        check_value("bus_o.dat (status)", 32'(dat), 32'(exp_expired));
        // run again with the interrupt masked
        bus_write(timer_addr(TMR_CTRL), 8'h01);
        exp_ctrl = 8'h01;
        repeat (2 * reload) begin
            @(posedge clk);
            #1;
            check_value("irq_o", 32'(irq_o), 32'(expected_irq()));
        end
        exp_expired = 1'b1;
        bus_read(timer_addr(TMR_STATUS), dat);
        check_value("bus_o.dat (status)", 32'(dat), 32'(exp_expired));
        bus_write(timer_addr(TMR_CTRL), 8'h00);
        exp_ctrl = 8'h00;
    endtask

    initial begin
        int seed_ret;
        rst_n_i          = 1'b0;
        reset_button_n_i = 1'b1;
        bus_i            = '0;
        seed_ret         = $urandom(RAND_SEED);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        check_reset_hold();
        check_ram();
        check_leds();
        check_prng();
        check_timer();
        if (uut.u_soc_assertions.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            abort_run($sformatf("%0d assertion failures", uut.u_soc_assertions.fail_count));
        end
    end

endmodule

// ==== sim/soc_assertions.sv ====
`timescale 1ns/1ps

module soc_assertions (
    input logic             clk,
    input logic             rst_n_i,
    input logic             sys_rst_i,
    input soc_pkg::wb_req_t bus_i,
    input logic             ack_i,
    input logic             irq_i
);
    import soc_pkg::*;

    // the testbench looks at this at the end of the run
    int   fail_count = 0;
    logic ctrl_wr;
    logic irq_en_seen;

    // timer ctrl write on the edge that accepts it
    assign ctrl_wr = bus_i.stb && !ack_i && bus_i.we
                     && bus_i.adr[ADDR_W-1 -: $bits(TIMER_PAGE)] == TIMER_PAGE
                     && timer_reg_e'(bus_i.adr[1:0]) == TMR_CTRL;

    // interrupt enable as software last wrote it
    always_ff @(posedge clk) begin
        if (sys_rst_i) begin
            irq_en_seen <= 1'b0;
        end else if (ctrl_wr) begin
            irq_en_seen <= bus_i.dat[TMR_CTRL_IE];
        end
    end

    ack_pulse: assert property (@(posedge clk) disable iff (!rst_n_i) ack_i |=> !ack_i)
    else begin
        fail_count++;
        $error("ack high for two cycles in a row");
    end

    // ack answers a strobe seen one cycle earlier
    ack_follows_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
                                      ack_i |-> $past(bus_i.stb))
    else begin
        fail_count++;
        $error("ack without a strobe in the previous cycle");
    end

    no_ack_in_reset: assert property (@(posedge clk) disable iff (!rst_n_i) sys_rst_i |-> !ack_i)
    else begin
        fail_count++;
        $error("ack while system reset is active");
    end

    irq_masked: assert property (@(posedge clk) disable iff (!rst_n_i) !irq_en_seen |-> !irq_i)
    else begin
        fail_count++;
        $error("irq high with interrupt enable clear");
    end

endmodule

// ==== logic/soc_top.sv ====
`timescale 1ns/1ps

module soc_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       reset_button_n_i,
    input  soc_pkg::wb_req_t           bus_i,
    output soc_pkg::wb_rsp_t           bus_o,
    output logic [soc_pkg::DATA_W-1:0] leds_o,
    output logic                       irq_o
);
    import soc_pkg::*;

    logic                  sys_rst;
    logic [NUM_SLAVES-1:0] slv_stb;
    wb_rsp_t               slv_rsp [NUM_SLAVES];

    reset_sequencer u_reset_sequencer (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .reset_button_n_i (reset_button_n_i),
        .sys_rst_o        (sys_rst)
    );

    bus_decoder u_bus_decoder (
        .bus_i (bus_i),
        .rsp_i (slv_rsp),
        .stb_o (slv_stb),
        .bus_o (bus_o)
    );

    led_port u_led_port (
        .clk    (clk),
        .rst_i  (sys_rst),
        .bus_i  (bus_i),
        .stb_i  (slv_stb[SLV_LEDS]),
        .rsp_o  (slv_rsp[SLV_LEDS]),
        .leds_o (leds_o)
    );

    interval_timer u_interval_timer (
        .clk   (clk),
        .rst_i (sys_rst),
        .bus_i (bus_i),
        .stb_i (slv_stb[SLV_TIMER]),
        .rsp_o (slv_rsp[SLV_TIMER]),
        .irq_o (irq_o)
    );

    prng_port u_prng_port (
        .clk   (clk),
        .rst_i (sys_rst),
        .bus_i (bus_i),
        .stb_i (slv_stb[SLV_PRNG]),
        .rsp_o (slv_rsp[SLV_PRNG])
    );

    // default region, takes every unclaimed address
    scratch_ram u_scratch_ram (
        .clk   (clk),
        .rst_i (sys_rst),
        .bus_i (bus_i),
        .stb_i (slv_stb[SLV_RAM]),
        .rsp_o (slv_rsp[SLV_RAM])
    );

endmodule

// ==== logic/scratch_ram.sv ====
`timescale 1ns/1ps

module scratch_ram (
    input  logic             clk,
    input  logic             rst_i,
    input  soc_pkg::wb_req_t bus_i,
    input  logic             stb_i,
    output soc_pkg::wb_rsp_t rsp_o
);
    import soc_pkg::*;

    logic [DATA_W-1:0]        mem [RAM_DEPTH];
    logic [RAM_ADDR_BITS-1:0] addr;
    logic                     ack;
    logic                     access;
    logic [DATA_W-1:0]        rd_dat;

    // upper address bits alias onto the same bytes
    assign addr   = bus_i.adr[RAM_ADDR_BITS-1:0];
    assign access = stb_i && !ack;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    // synchronous read, fits a block ram
    always_ff @(posedge clk) begin
        if (access) begin
            if (bus_i.we) begin
                mem[addr] <= bus_i.dat;
            end
            rd_dat <= mem[addr];
        end
    end

    assign rsp_o = '{dat: rd_dat, ack: ack};

endmodule

// ==== logic/prng_port.sv ====
`timescale 1ns/1ps

module prng_port (
    input  logic             clk,
    input  logic             rst_i,
    input  soc_pkg::wb_req_t bus_i,
    input  logic             stb_i,
    output soc_pkg::wb_rsp_t rsp_o
);
    import soc_pkg::*;

    logic                                 ack;
    logic                                 access;
    logic [PRNG_SEL_W-1:0]                byte_sel;
    logic [PRNG_BYTES-1:0][DATA_W-1:0]    state;
    logic [DATA_W-1:0]                    rd_dat;

    // xorshift32 with shifts 13, 17, 5
    function automatic logic [PRNG_BYTES*DATA_W-1:0] xorshift32(
        input logic [PRNG_BYTES*DATA_W-1:0] s
    );
        logic [PRNG_BYTES*DATA_W-1:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    assign access   = stb_i && !ack;
    assign byte_sel = bus_i.adr[PRNG_SEL_W-1:0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack   <= 1'b0;
            state <= PRNG_RESET_STATE;
        end else begin
            ack <= access;
            if (access && bus_i.we) begin
                state[byte_sel] <= bus_i.dat;
            end else if (access && byte_sel == '0) begin
                // reading the low byte consumes it
                state <= xorshift32(state);
            end
        end
    end

    // byte is taken before the step
    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat <= state[byte_sel];
        end
    end

    assign rsp_o = '{dat: rd_dat, ack: ack};

endmodule

// ==== logic/interval_timer.sv ====
`timescale 1ns/1ps

module interval_timer (
    input  logic             clk,
    input  logic             rst_i,
    input  soc_pkg::wb_req_t bus_i,
    input  logic             stb_i,
    output soc_pkg::wb_rsp_t rsp_o,
    output logic             irq_o
);
    import soc_pkg::*;

    timer_reg_e         reg_sel;
    logic               ack;
    logic               access;
    logic               wr;
    logic [TIMER_W-1:0] reload;
    logic [TIMER_W-1:0] count;
    logic               enable;
    logic               irq_en;
    logic               expired;
    logic [DATA_W-1:0]  rd_next;
    logic [DATA_W-1:0]  rd_dat;

    assign reg_sel = timer_reg_e'(bus_i.adr[$bits(timer_reg_e)-1:0]);
    assign access  = stb_i && !ack;
    assign wr      = access && bus_i.we;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack     <= 1'b0;
            reload  <= '0;
            count   <= '0;
            enable  <= 1'b0;
            irq_en  <= 1'b0;
            expired <= 1'b0;
        end else begin
            ack <= access;
            if (wr) begin
                case (reg_sel)
                    TMR_RELOAD_LO: reload[DATA_W-1:0]       <= bus_i.dat;
                    TMR_RELOAD_HI: reload[TIMER_W-1:DATA_W] <= bus_i.dat;
                    TMR_CTRL: begin
                        enable <= bus_i.dat[TMR_CTRL_EN];
                        irq_en <= bus_i.dat[TMR_CTRL_IE];
                    end
                    TMR_STATUS: begin
                        if (bus_i.dat[TMR_STAT_EXP]) begin
                            expired <= 1'b0;
                        end
                    end
                endcase
            end
            // start from reload on the enable rising edge
            if (wr && reg_sel == TMR_CTRL && bus_i.dat[TMR_CTRL_EN] && !enable) begin
                count <= reload;
            end else if (enable) begin
                if (count == '0) begin
                    // set beats a clear in the same cycle
                    expired <= 1'b1;
                    count   <= reload;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_comb begin
        rd_next = '0;
        case (reg_sel)
            TMR_RELOAD_LO: rd_next = reload[DATA_W-1:0];
            TMR_RELOAD_HI: rd_next = reload[TIMER_W-1:DATA_W];
            TMR_CTRL: begin
                rd_next[TMR_CTRL_EN] = enable;
                rd_next[TMR_CTRL_IE] = irq_en;
            end
            TMR_STATUS: rd_next[TMR_STAT_EXP] = expired;
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat <= rd_next;
        end
    end

    assign rsp_o = '{dat: rd_dat, ack: ack};
    assign irq_o = expired && irq_en;

endmodule

// ==== logic/led_port.sv ====
`timescale 1ns/1ps

module led_port (
    input  logic                        clk,
    input  logic                        rst_i,
    input  soc_pkg::wb_req_t            bus_i,
    input  logic                        stb_i,
    output soc_pkg::wb_rsp_t            rsp_o,
    output logic [soc_pkg::DATA_W-1:0]  leds_o
);

    logic ack;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack    <= 1'b0;
            leds_o <= '0;
        end else begin
            // one cycle ack pulse per strobe
            ack <= stb_i && !ack;
            if (stb_i && !ack && bus_i.we) begin
                leds_o <= bus_i.dat;
            end
        end
    end

    // readback shows the register as it is now
    assign rsp_o = '{dat: leds_o, ack: ack};

endmodule

// ==== logic/bus_decoder.sv ====
`timescale 1ns/1ps

module bus_decoder (
    input  soc_pkg::wb_req_t             bus_i,
    input  soc_pkg::wb_rsp_t             rsp_i [soc_pkg::NUM_SLAVES],
    output logic [soc_pkg::NUM_SLAVES-1:0] stb_o,
    output soc_pkg::wb_rsp_t             bus_o
);
    import soc_pkg::*;

    slave_e sel;

    // page match, anything unclaimed falls through to ram
    always_comb begin
        if (bus_i.adr[ADDR_W-1 -: $bits(TIMER_PAGE)] == TIMER_PAGE) begin
            sel = SLV_TIMER;
        end else if (bus_i.adr[ADDR_W-1 -: $bits(PRNG_PAGE)] == PRNG_PAGE) begin
            sel = SLV_PRNG;
        end else if (bus_i.adr[ADDR_W-1 -: $bits(LEDS_PAGE)] == LEDS_PAGE) begin
            sel = SLV_LEDS;
        end else begin
            sel = SLV_RAM;
        end
    end

    // only the selected slave sees the strobe
    always_comb begin
        stb_o      = '0;
        stb_o[sel] = bus_i.stb;
    end

    assign bus_o = rsp_i[sel];

endmodule

// ==== logic/reset_sequencer.sv ====
`timescale 1ns/1ps

module reset_sequencer (
    input  logic clk,
    input  logic rst_n_i,
    input  logic reset_button_n_i,
    output logic sys_rst_o
);
    import soc_pkg::*;

    logic                  reset_req;
    logic [HOLD_CNT_W-1:0] hold_cnt;

    // either source low counts as a request
    assign reset_req = !rst_n_i || !reset_button_n_i;

    always_ff @(posedge clk) begin
        if (reset_req) begin
            // any request restarts the hold time
            hold_cnt  <= '0;
            sys_rst_o <= 1'b1;
        end else if (sys_rst_o) begin
            if (hold_cnt == HOLD_CNT_W'(RESET_HOLD_CYCLES - 1)) begin
                sys_rst_o <= 1'b0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== logic/soc_pkg.sv ====
package soc_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 8;

    // master request, held stable until the slave acks
    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic              we;
        logic              stb;
    } wb_req_t;

    // slave response, dat is valid while ack is high
    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        SLV_RAM,
        SLV_TIMER,
        SLV_PRNG,
        SLV_LEDS
    } slave_e;

    localparam int NUM_SLAVES = 4;

    // upper address bits of each peripheral page
    localparam logic [23:0] TIMER_PAGE = 24'hFFFFFD;
    localparam logic [23:0] PRNG_PAGE  = 24'hFFFFFE;
    localparam logic [27:0] LEDS_PAGE  = 28'hFFFFFFF;

    // scratch ram takes the low address bits
    localparam int RAM_ADDR_BITS = 10;
    localparam int RAM_DEPTH     = 2 ** RAM_ADDR_BITS;

    localparam int RESET_HOLD_CYCLES = 32;
    localparam int HOLD_CNT_W        = $clog2(RESET_HOLD_CYCLES);

    localparam int TIMER_W = 16;

    typedef enum logic [1:0] {
        TMR_RELOAD_LO,
        TMR_RELOAD_HI,
        TMR_CTRL,
        TMR_STATUS
    } timer_reg_e;

    // timer register bit positions
    localparam int TMR_CTRL_EN  = 0;
    localparam int TMR_CTRL_IE  = 1;
    localparam int TMR_STAT_EXP = 0;

    localparam int PRNG_BYTES = 4;
    localparam int PRNG_SEL_W = $clog2(PRNG_BYTES);
    localparam logic [PRNG_BYTES*DATA_W-1:0] PRNG_RESET_STATE = 32'h2545F491;

endpackage
